/* t08_lcd_pkg.sv */
`default_nettype none

package t08_lcd_pkg;

  // host command opcodes
  typedef enum logic [1:0] {
    OP_CMD   = 2'd0,
    // parameter byte with dcx high
    OP_PARAM = 2'd1,
    OP_READ  = 2'd2,
    // repeated parameter write, count+1 times
    OP_FILL  = 2'd3
  } t08_op_e;

  // command word from the host, 18 bits
  typedef struct packed {
    t08_op_e    opcode;
    // repeat count, only meaningful for fill
    logic [7:0] count;
    logic [7:0] data;
  } t08_cmd_t;

  // kind of a single bus operation
  typedef enum logic [1:0] {
    // command byte, dcx low
    BUS_WR_CMD  = 2'd0,
    // parameter byte, dcx high
    BUS_WR_DATA = 2'd1,
    // one byte read from the panel
    BUS_RD      = 2'd2
  } t08_bus_kind_e;

  // strobe sequencer states
  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    // csx low, dcx settles
    ST_SETUP  = 2'd1,
    // wrx or rdx low
    ST_STROBE = 2'd2,
    // strobes back high, done pulse
    ST_HOLD   = 2'd3
  } t08_exec_state_e;

endpackage

`default_nettype wire

/* t08_lcd_op_if.sv */
`timescale 1ns/1ns
`default_nettype none

// one bus operation from decode to execute
interface t08_lcd_op_if;

  logic                         valid;
  t08_lcd_pkg::t08_bus_kind_e   kind;
  logic [7:0]                   data;
  // final op of a command
  logic                         last;
  // execute is idle and takes the op
  logic                         ready;
  // bus cycle of the op has ended
  logic                         done;

  modport decode_mp (
    output valid, kind, data, last,
    input  ready
  );

  modport exec_mp (
    input  valid, kind, data, last,
    output ready, done
  );

endinterface

`default_nettype wire

/* t08_cmd_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module t08_cmd_decode #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                  hwclk,
  input  logic                  reset,
  input  logic                  cmd_valid,
  input  t08_lcd_pkg::t08_cmd_t cmd_word,
  t08_lcd_op_if.decode_mp       op
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  // command storage
  t08_lcd_pkg::t08_cmd_t mem [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] fifo_cnt;
  logic             fifo_empty;
  logic             pop;

  // command currently being expanded
  logic                 busy;
  t08_lcd_pkg::t08_op_e cur_op;
  logic [7:0]           cur_data;
  // ops left after the current one
  logic [7:0]           rep_cnt;

  logic xfer;

  assign fifo_empty = (fifo_cnt == '0);
  assign xfer       = op.valid && op.ready;

  // load next command when the stage is free or its last op leaves now
  assign pop = !fifo_empty && (!busy || (xfer && op.last));

  // write side, credits guarantee room
  always_ff @(posedge hwclk) begin
    if (cmd_valid) begin
      mem[wr_ptr] <= cmd_word;
    end
  end

  always_ff @(posedge hwclk) begin
    if (reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fifo_cnt <= '0;
    end else begin
      if (cmd_valid) begin
        // wrap after the last entry
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({cmd_valid, pop})
        2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
        2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
        default: fifo_cnt <= fifo_cnt;
      endcase
    end
  end

  // expansion stage control
  always_ff @(posedge hwclk) begin
    if (reset) begin
      busy    <= 1'b0;
      cur_op  <= t08_lcd_pkg::OP_CMD;
      rep_cnt <= '0;
    end else if (pop) begin
      busy    <= 1'b1;
      cur_op  <= mem[rd_ptr].opcode;
      // only fill repeats
      rep_cnt <= (mem[rd_ptr].opcode == t08_lcd_pkg::OP_FILL) ? mem[rd_ptr].count : 8'd0;
    end else if (xfer) begin
      if (op.last) begin
        busy <= 1'b0;
      end else begin
        rep_cnt <= rep_cnt - 1'b1;
      end
    end
  end

  // payload byte
  always_ff @(posedge hwclk) begin
    if (pop) begin
      cur_data <= mem[rd_ptr].data;
    end
  end

  assign op.valid = busy;
  assign op.data  = cur_data;
  assign op.last  = (rep_cnt == 8'd0);

  // opcode to bus kind
  always_comb begin
    case (cur_op)
      t08_lcd_pkg::OP_CMD:  op.kind = t08_lcd_pkg::BUS_WR_CMD;
      t08_lcd_pkg::OP_READ: op.kind = t08_lcd_pkg::BUS_RD;
      // param and fill both write data bytes
      default:              op.kind = t08_lcd_pkg::BUS_WR_DATA;
    endcase
  end

endmodule

`default_nettype wire

/* t08_bus_execute.sv */
`timescale 1ns/1ns
`default_nettype none

module t08_bus_execute #(
  parameter int STROBE_CYCLES = 2
) (
  input  logic           hwclk,
  input  logic           reset,
  t08_lcd_op_if.exec_mp  op,
  input  logic [7:0]     lcd_din,
  output logic [7:0]     lcd_dout,
  output logic           lcd_oe,
  output logic           wrx,
  output logic           rdx,
  output logic           csx,
  output logic           dcx,
  output logic           op_done,
  output logic           op_last,
  output logic           op_read,
  output logic [7:0]     op_rdata
);

  localparam int STB_W = (STROBE_CYCLES > 1) ? $clog2(STROBE_CYCLES) : 1;

  t08_lcd_pkg::t08_exec_state_e state;
  logic [STB_W-1:0]             strobe_cnt;
  logic                         strobe_end;

  // op held for the whole bus cycle
  t08_lcd_pkg::t08_bus_kind_e kind_q;
  logic [7:0]                 data_q;
  logic                       last_q;
  logic [7:0]                 rdata_q;

  logic is_read;
  logic take;

  assign is_read    = (kind_q == t08_lcd_pkg::BUS_RD);
  assign take       = op.valid && op.ready;
  assign strobe_end = (strobe_cnt == STB_W'(STROBE_CYCLES - 1));

  always_ff @(posedge hwclk) begin
    if (reset) begin
      state      <= t08_lcd_pkg::ST_IDLE;
      strobe_cnt <= '0;
      kind_q     <= t08_lcd_pkg::BUS_WR_CMD;
      last_q     <= 1'b0;
    end else begin
      case (state)
        t08_lcd_pkg::ST_IDLE: begin
          if (take) begin
            kind_q <= op.kind;
            last_q <= op.last;
            state  <= t08_lcd_pkg::ST_SETUP;
          end
        end
        t08_lcd_pkg::ST_SETUP: begin
          // one cycle of address setup before the strobe
          strobe_cnt <= '0;
          state      <= t08_lcd_pkg::ST_STROBE;
        end
        t08_lcd_pkg::ST_STROBE: begin
          if (strobe_end) begin
            state <= t08_lcd_pkg::ST_HOLD;
          end else begin
            strobe_cnt <= strobe_cnt + 1'b1;
          end
        end
        default: begin
          // hold cycle, strobes already high
          state <= t08_lcd_pkg::ST_IDLE;
        end
      endcase
    end
  end

  // write byte captured at the transfer
  always_ff @(posedge hwclk) begin
    if (take) begin
      data_q <= op.data;
    end
  end

  // sample panel data in the last low cycle of rdx
  always_ff @(posedge hwclk) begin
    if (state == t08_lcd_pkg::ST_STROBE && strobe_end && is_read) begin
      rdata_q <= lcd_din;
    end
  end

  // handshake back to decode
  assign op.ready = (state == t08_lcd_pkg::ST_IDLE);
  assign op.done  = (state == t08_lcd_pkg::ST_HOLD);

  // chip select covers setup, strobe and hold
  assign csx = (state == t08_lcd_pkg::ST_IDLE);
  assign wrx = !(state == t08_lcd_pkg::ST_STROBE && !is_read);
  assign rdx = !(state == t08_lcd_pkg::ST_STROBE && is_read);
  // low only for command bytes
  assign dcx = (kind_q != t08_lcd_pkg::BUS_WR_CMD);

  // drive the pads only while a write is on the bus
  assign lcd_oe   = (state != t08_lcd_pkg::ST_IDLE) && !is_read;
  assign lcd_dout = data_q;

  // status to the result block
  assign op_done  = op.done;
  assign op_last  = last_q;
  assign op_read  = is_read;
  assign op_rdata = rdata_q;

endmodule

`default_nettype wire

/* t08_read_result.sv */
`timescale 1ns/1ns
`default_nettype none

module t08_read_result #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic       hwclk,
  input  logic       reset,
  input  logic       cmd_valid,
  input  logic       op_done,
  input  logic       op_last,
  input  logic       op_read,
  input  logic [7:0] op_rdata,
  output logic       credit_return,
  output logic       rd_valid,
  output logic [7:0] rd_data,
  output logic       idle
);

  localparam int PEND_W = $clog2(FIFO_DEPTH + 1);

  // commands sent but not yet credited back
  logic [PEND_W-1:0] pending;
  logic              cmd_end;

  assign cmd_end = op_done && op_last;

  always_ff @(posedge hwclk) begin
    if (reset) begin
      credit_return <= 1'b0;
      rd_valid      <= 1'b0;
    end else begin
      credit_return <= cmd_end;
      // a read is always a single-op command
      rd_valid      <= cmd_end && op_read;
    end
  end

  always_ff @(posedge hwclk) begin
    if (op_done && op_read) begin
      rd_data <= op_rdata;
    end
  end

  always_ff @(posedge hwclk) begin
    if (reset) begin
      pending <= '0;
    end else begin
      case ({cmd_valid, credit_return})
        2'b10:   pending <= pending + 1'b1;
        2'b01:   pending <= pending - 1'b1;
        default: pending <= pending;
      endcase
    end
  end

  assign idle = (pending == '0);

endmodule

`default_nettype wire

/* t08_lcd_top.sv */
`timescale 1ns/1ns
`default_nettype none

module t08_lcd_top #(
  parameter int FIFO_DEPTH    = 4,
  parameter int STROBE_CYCLES = 2
) (
  input  logic                  hwclk,
  input  logic                  reset,

  // host side
  input  logic                  cmd_valid,
  input  t08_lcd_pkg::t08_cmd_t cmd_word,
  output logic                  credit_return,
  output logic                  rd_valid,
  output logic [7:0]            rd_data,
  output logic                  idle,

  // 8080 style panel bus
  output logic [7:0]            lcd_dout,
  output logic                  lcd_oe,
  input  logic [7:0]            lcd_din,
  output logic                  wrx,
  output logic                  rdx,
  output logic                  csx,
  output logic                  dcx
);

  // decode to execute
  t08_lcd_op_if lcd_op ();

  // execute to result
  logic       op_done;
  logic       op_last;
  logic       op_read;
  logic [7:0] op_rdata;

  t08_cmd_decode #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) i_decode (
    .hwclk(hwclk), .reset(reset),
    .cmd_valid(cmd_valid), .cmd_word(cmd_word),
    .op(lcd_op.decode_mp)
  );

  t08_bus_execute #(
    .STROBE_CYCLES(STROBE_CYCLES)
  ) i_execute (
    .hwclk(hwclk), .reset(reset),
    .op(lcd_op.exec_mp),
    .lcd_din(lcd_din), .lcd_dout(lcd_dout), .lcd_oe(lcd_oe),
    .wrx(wrx), .rdx(rdx), .csx(csx), .dcx(dcx),
    .op_done(op_done), .op_last(op_last), .op_read(op_read), .op_rdata(op_rdata)
  );

  t08_read_result #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) i_result (
    .hwclk(hwclk), .reset(reset),
    .cmd_valid(cmd_valid),
    .op_done(op_done), .op_last(op_last), .op_read(op_read), .op_rdata(op_rdata),
    .credit_return(credit_return), .rd_valid(rd_valid), .rd_data(rd_data),
    .idle(idle)
  );

endmodule

`default_nettype wire

/* t08_panel_model.sv */
`timescale 1ns/1ns
`default_nettype none

// 8080 panel seen from the pins, sampled on the falling clock edge
module t08_panel_model (
  input  logic       hwclk,
  input  logic       reset,
  input  logic [7:0] lcd_dout,
  input  logic       lcd_oe,
  output logic [7:0] lcd_din,
  input  logic       wrx,
  input  logic       rdx,
  input  logic       csx,
  input  logic       dcx,
  // one record per completed write, {dcx, byte}
  output logic       rec_valid,
  output logic [8:0] rec,
  // sticky strobe protocol error
  output logic       fault
);

  logic       wrx_q;
  logic       wr_end;
  logic [7:0] last_cmd;
  logic [7:0] din_q = 8'h00;

  // write completes on the rising wrx edge, csx still low in hold
  assign wr_end  = wrx && !wrx_q && !csx;
  assign lcd_din = din_q;

  always @(negedge hwclk) begin
    if (reset) begin
      wrx_q     <= 1'b1;
      last_cmd  <= 8'h00;
      rec_valid <= 1'b0;
      rec       <= '0;
      fault     <= 1'b0;
      din_q     <= 8'h00;
    end else begin
      wrx_q     <= wrx;
      rec_valid <= wr_end;
      rec       <= {dcx, lcd_dout};
      if (wr_end && !dcx) begin
        last_cmd <= lcd_dout;
      end
      // answer only while rdx is low
      din_q <= rdx ? 8'h00 : (last_cmd ^ 8'h5a);
      // no write strobe or driven pads during a read, no strobe without csx
      if ((!rdx && (!wrx || lcd_oe)) || ((!rdx || !wrx) && csx)) begin
        fault <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* t08_lcd_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module t08_lcd_tb;

  localparam int FIFO_DEPTH    = 4;
  localparam int STROBE_CYCLES = 2;
  // a full 256 byte fill is the longest gap between credits
  localparam int WAIT_LIMIT    = 8000;

  logic                  hwclk, reset, cmd_valid;
  t08_lcd_pkg::t08_cmd_t cmd_word;
  logic                  credit_return, rd_valid, idle, fault;
  logic [7:0]            rd_data, lcd_dout, lcd_din;
  logic                  lcd_oe, wrx, rdx, csx, dcx, rec_valid;
  logic [8:0]            rec;

  // expected panel writes as {dcx, byte}, expected read bytes
  logic [8:0] exp_rec [$];
  logic [7:0] exp_rd [$];
  // command byte the panel holds once earlier commands are on the bus
  logic [7:0] model_cmd;
  int         credits, sent, returned, errors, checks;
  bit         hung;

  t08_lcd_top #(.FIFO_DEPTH(FIFO_DEPTH), .STROBE_CYCLES(STROBE_CYCLES)) i_dut (
    .hwclk(hwclk), .reset(reset), .cmd_valid(cmd_valid), .cmd_word(cmd_word),
    .credit_return(credit_return), .rd_valid(rd_valid), .rd_data(rd_data), .idle(idle),
    .lcd_dout(lcd_dout), .lcd_oe(lcd_oe), .lcd_din(lcd_din),
    .wrx(wrx), .rdx(rdx), .csx(csx), .dcx(dcx)
  );

  t08_panel_model i_panel (
    .hwclk(hwclk), .reset(reset), .lcd_dout(lcd_dout), .lcd_oe(lcd_oe), .lcd_din(lcd_din),
    .wrx(wrx), .rdx(rdx), .csx(csx), .dcx(dcx),
    .rec_valid(rec_valid), .rec(rec), .fault(fault)
  );

  initial begin
    hwclk = 1'b0;
    forever #5 hwclk = ~hwclk;
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("mismatch %s: got %0h, expected %0h", name, got, want);
    end
  endtask

  // mode 0 cmd/param, 1 cmd/fill, 2 cmd/read, 3 any opcode with short fills
  function automatic t08_lcd_pkg::t08_cmd_t make_cmd(input int mode);
    t08_lcd_pkg::t08_cmd_t c;
    logic                  coin;
    coin    = 1'($urandom);
    c.data  = 8'($urandom);
    c.count = 8'($urandom);
    case (mode)
      0:       c.opcode = coin ? t08_lcd_pkg::OP_PARAM : t08_lcd_pkg::OP_CMD;
      1:       c.opcode = coin ? t08_lcd_pkg::OP_FILL : t08_lcd_pkg::OP_CMD;
      2:       c.opcode = coin ? t08_lcd_pkg::OP_READ : t08_lcd_pkg::OP_CMD;
      default: begin
        c.opcode = t08_lcd_pkg::t08_op_e'(2'($urandom));
        c.count  = c.count & 8'h07;
      end
    endcase
    return c;
  endfunction

  // reference model of the bus traffic of one command
  function automatic void expand_cmd(input t08_lcd_pkg::t08_cmd_t c);
    case (c.opcode)
      t08_lcd_pkg::OP_CMD: begin
        exp_rec.push_back({1'b0, c.data});
        model_cmd = c.data;
      end
      t08_lcd_pkg::OP_PARAM: exp_rec.push_back({1'b1, c.data});
      t08_lcd_pkg::OP_FILL: begin
        for (int i = 0; i <= int'(c.count); i++) begin
          exp_rec.push_back({1'b1, c.data});
        end
      end
      // panel answers with its last command byte
      default: exp_rd.push_back(model_cmd ^ 8'h5a);
    endcase
  endfunction

  // one host cycle: collect credits and results, then maybe send
  task automatic cycle(input bit want, input int mode, output bit did);
    t08_lcd_pkg::t08_cmd_t c;
    @(negedge hwclk);
    if (credit_return) begin
      credits++;
      returned++;
    end
    if (credits > FIFO_DEPTH) begin
      errors++;
      $display("credit returned with no command outstanding");
    end
    if (rd_valid) begin
      check_val("credit_return at rd_valid", credit_return, 1);
      if (exp_rd.size() == 0) begin
        errors++;
        $display("read result arrived with no read outstanding");
      end else begin
        check_val("rd_data", rd_data, exp_rd.pop_front());
      end
    end
    did       = want && (credits > 0);
    cmd_valid = did;
    cmd_word  = '0;
    if (did) begin
      c        = make_cmd(mode);
      cmd_word = c;
      credits--;
      sent++;
      expand_cmd(c);
    end
  endtask

  task automatic stall(input int num, input int waited);
    if (waited > WAIT_LIMIT && !hung) begin
      hung = 1'b1;
      errors++;
      $display("test %0d timed out waiting for the controller", num);
    end
  endtask

  task automatic run_test(input int num, input string name, input int n, input int mode);
    int err_before;
    int k;
    int waited;
    bit did;
    err_before = errors;
    k          = 0;
    waited     = 0;
    // full rate, held back only by credits
    while (k < n && !hung) begin
      cycle(1'b1, mode, did);
      waited = did ? 0 : waited + 1;
      k      = did ? k + 1 : k;
      stall(num, waited);
    end
    waited = 0;
    // last record or read byte and the last credit land in the same host cycle
    while (!hung && (exp_rec.size() != 0 || exp_rd.size() != 0)) begin
      cycle(1'b0, mode, did);
      waited++;
      stall(num, waited);
    end
    // pending count drops a cycle after the last credit
    cycle(1'b0, mode, did);
    check_val("idle", idle, 1);
    check_val("credit_return count", returned, sent);
    check_val("panel fault", fault, 0);
    if (errors == err_before) begin
      $display("test %0d %s: ok, %0d commands", num, name, n);
    end else begin
      $display("test %0d %s: failed, %0d errors", num, name, errors - err_before);
    end
  endtask

  // panel writes in bus order against the model
  always @(posedge hwclk) begin
    if (rec_valid) begin
      if (exp_rec.size() == 0) begin
        errors++;
        $display("panel saw a write %0h with no write expected", rec);
      end else begin
        check_val("panel {dcx,data}", rec, exp_rec.pop_front());
      end
    end
  end

  initial begin
    void'($urandom(32'h2f44));
    reset     = 1'b1;
    cmd_valid = 1'b0;
    cmd_word  = '0;
    model_cmd = 8'h00;
    credits   = FIFO_DEPTH;
    sent      = 0;
    returned  = 0;
    errors    = 0;
    checks    = 0;
    hung      = 1'b0;
    repeat (4) @(posedge hwclk);
    @(negedge hwclk);
    reset = 1'b0;

    check_val("csx", csx, 1);
    check_val("wrx", wrx, 1);
    check_val("rdx", rdx, 1);
    check_val("lcd_oe", lcd_oe, 0);
    check_val("idle", idle, 1);
    check_val("credit_return", credit_return, 0);
    $display("test 1 reset_state: %s", (errors == 0) ? "ok" : "failed");

    run_test(2, "cmd_param_order", 40, 0);
    run_test(3, "fill_count", 12, 1);
    run_test(4, "read_back", 30, 2);
    run_test(5, "credit_flow", 60, 3);

    $display("tests 5, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
t08_lcd_pkg.sv
t08_lcd_op_if.sv
t08_cmd_decode.sv
t08_bus_execute.sv
t08_read_result.sv
t08_lcd_top.sv
t08_panel_model.sv
t08_lcd_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module t08_lcd_tb \
  -f compile.f --Mdir obj_dir -o t08_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/t08_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
  exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
  echo "no result line in sim.log"
  exit 1
fi
exit 0
